//--- flist.f
+incdir+hdl
hdl/awg_data_pkg.sv
hdl/awg_cfg_pkg.sv
hdl/awg_config_regs.sv
hdl/awg_sequencer.sv
hdl/awg_wave_mem.sv
hdl/awg_output_stage.sv
hdl/awg_top.sv
tb/tb_awg.sv

//--- hdl/awg_cfg_pkg.sv
//////////////////////////////////////////////////
// awg configuration types
// trigger modes, field select and the 32 bit
// configuration word with its two decodings
//////////////////////////////////////////////////

`default_nettype none

`include "awg_params.svh"

package awg_cfg_pkg;

  // how a channel raises its trigger output
  typedef enum logic [1:0] {
    TRIG_NONE  = 2'd0,
    TRIG_BURST = 2'd1,
    TRIG_FRAME = 2'd2
  } trig_mode_e;

  // which half of the channel config a write targets
  typedef enum logic {
    CFG_FRAME = 1'b0,
    CFG_BURST = 1'b1
  } cfg_sel_e;

  // burst decoding, frame count sits in the low bits
  typedef struct packed {
    logic [31-`AWG_BURST_WIDTH:0] rsvd;
    logic [`AWG_BURST_WIDTH-1:0]  frames;
  } cfg_burst_t;

  // frame decoding, last address is depth minus one
  typedef struct packed {
    logic [29-$clog2(`AWG_DEPTH):0]  rsvd;
    trig_mode_e                      mode;
    logic [$clog2(`AWG_DEPTH)-1:0]   last_addr;
  } cfg_frame_t;

  // one word, read either way depending on cfg_sel
  typedef union packed {
    cfg_burst_t burst;
    cfg_frame_t frame;
  } cfg_word_u;

endpackage

`default_nettype wire

//--- hdl/awg_config_regs.sv
//////////////////////////////////////////////////
// awg configuration registers
// per-channel frame depth, trigger mode and burst
// length, writable only while playback is idle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module awg_config_regs
  import awg_data_pkg::*;
  import awg_cfg_pkg::*;
(
  input  wire logic                                       dac_clk,
  input  wire logic                                       dac_reset,
  input  wire logic                                       awg_busy,
  input  wire logic                                       cfg_wr,
  input  wire chan_idx_t                                  cfg_chan,
  input  wire cfg_sel_e                                   cfg_sel,
  input  wire cfg_word_u                                  cfg_word,
  output mem_addr_t  [`AWG_CHANNELS-1:0]                  last_addr,
  output trig_mode_e [`AWG_CHANNELS-1:0]                  trig_mode,
  output logic       [`AWG_CHANNELS-1:0][`AWG_BURST_WIDTH-1:0] last_frame
);

  // writes only land while the sequencer is idle
  logic cfg_accept;
  // stored value is count minus one, zero count still plays one frame
  logic [`AWG_BURST_WIDTH-1:0] burst_last;

  assign cfg_accept = cfg_wr && !awg_busy;

  assign burst_last = (cfg_word.burst.frames == '0) ? '0 : cfg_word.burst.frames - 1'b1;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      last_addr  <= '0;
      last_frame <= '0;
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        trig_mode[ch] <= TRIG_NONE;
      end
    end else if (cfg_accept) begin
      case (cfg_sel)
        CFG_FRAME: begin
          last_addr[cfg_chan] <= cfg_word.frame.last_addr;
          trig_mode[cfg_chan] <= cfg_word.frame.mode;
        end
        CFG_BURST: last_frame[cfg_chan] <= burst_last;
        default: ;
      endcase
    end
  end

  // sequencer relies on a frozen config for the whole burst
  assert property (@(posedge dac_clk) disable iff (dac_reset)
    awg_busy |=> $stable(last_addr) && $stable(trig_mode) && $stable(last_frame))
    else $error("config changed during playback");

endmodule

`default_nettype wire

//--- hdl/awg_data_pkg.sv
//////////////////////////////////////////////////
// awg datapath types
// addresses, channel index and sample words
//////////////////////////////////////////////////

`default_nettype none

`include "awg_params.svh"

package awg_data_pkg;

  // word address inside one channel memory
  typedef logic [$clog2(`AWG_DEPTH)-1:0] mem_addr_t;

  // selects one channel
  typedef logic [$clog2(`AWG_CHANNELS)-1:0] chan_idx_t;

  // one memory word of parallel samples, sample 0 in the low bits
  typedef logic [`AWG_PAR_SAMPLES*`AWG_SAMPLE_WIDTH-1:0] sample_word_t;

  // one word per channel, channel 0 in the low bits
  typedef sample_word_t [`AWG_CHANNELS-1:0] chan_words_t;

endpackage

`default_nettype wire

//--- hdl/awg_output_stage.sv
//////////////////////////////////////////////////
// awg output stage
// realigns zero select, triggers and valid with
// the memory data and registers the dac outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module awg_output_stage
  import awg_data_pkg::*;
(
  input  wire logic                        dac_clk,
  input  wire logic                        dac_reset,
  input  wire logic [`AWG_CHANNELS-1:0]    zero_sel,
  input  wire logic [`AWG_CHANNELS-1:0]    raw_trig,
  input  wire logic                        started,
  input  wire chan_words_t                 rd_data,
  output chan_words_t                      dac_data,
  output logic [`AWG_CHANNELS-1:0]         dac_trigger,
  output logic                             dac_valid
);

  // two stage delay, matches the memory read latency
  logic [1:0][`AWG_CHANNELS-1:0] zero_sel_d;
  logic [1:0][`AWG_CHANNELS-1:0] raw_trig_d;
  logic [1:0]                    started_d;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      // zero select starts high so nothing leaks from uninitialized memory
      zero_sel_d  <= '1;
      raw_trig_d  <= '0;
      started_d   <= '0;
      dac_data    <= '0;
      dac_trigger <= '0;
      dac_valid   <= 1'b0;
    end else begin
      zero_sel_d  <= {zero_sel_d[0], zero_sel};
      raw_trig_d  <= {raw_trig_d[0], raw_trig};
      started_d   <= {started_d[0], started};
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        dac_data[ch] <= zero_sel_d[1][ch] ? '0 : rd_data[ch];
      end
      dac_trigger <= raw_trig_d[1];
      dac_valid   <= started_d[1];
    end
  end

  // a gated address must come out as zero three cycles later
  for (genvar ch = 0; ch < `AWG_CHANNELS; ch++) begin : g_zero_chk
    assert property (@(posedge dac_clk) disable iff (dac_reset)
      $past(zero_sel[ch], 3) |-> (dac_data[ch] == '0))
      else $error("nonzero output on gated channel %0d", ch);
  end

endmodule

`default_nettype wire

//--- hdl/awg_params.svh
//////////////////////////////////////////////////
// awg sizing macros
// channel count, memory geometry, sample format
// and the width of the per-channel frame counter
//////////////////////////////////////////////////

`ifndef AWG_PARAMS_SVH
`define AWG_PARAMS_SVH

// number of parallel output channels
`define AWG_CHANNELS 4

// words held by each channel memory
`define AWG_DEPTH 64

// samples packed into one memory word
`define AWG_PAR_SAMPLES 2

// bits per dac sample
`define AWG_SAMPLE_WIDTH 16

// frame counter width, so up to 65535 frames per burst
`define AWG_BURST_WIDTH 16

`endif

//--- hdl/awg_sequencer.sv
//////////////////////////////////////////////////
// awg playback sequencer
// idle/active control, per-channel read address,
// frame count, done flags and trigger marks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module awg_sequencer
  import awg_data_pkg::*;
  import awg_cfg_pkg::*;
(
  input  wire logic                                            dac_clk,
  input  wire logic                                            dac_reset,
  input  wire logic                                            awg_start,
  input  wire logic                                            awg_stop,
  input  wire mem_addr_t  [`AWG_CHANNELS-1:0]                  last_addr,
  input  wire trig_mode_e [`AWG_CHANNELS-1:0]                  trig_mode,
  input  wire logic [`AWG_CHANNELS-1:0][`AWG_BURST_WIDTH-1:0]  last_frame,
  output logic                                                 awg_busy,
  output logic                                                 started,
  output mem_addr_t  [`AWG_CHANNELS-1:0]                       rd_addr,
  output logic       [`AWG_CHANNELS-1:0]                       zero_sel,
  output logic       [`AWG_CHANNELS-1:0]                       raw_trig
);

  typedef enum logic {SEQ_IDLE, SEQ_ACTIVE} seq_state_e;

  seq_state_e                                     state;
  logic [`AWG_CHANNELS-1:0]                       done;
  logic [`AWG_CHANNELS-1:0][`AWG_BURST_WIDTH-1:0] frame_cnt;

  assign awg_busy = (state == SEQ_ACTIVE);

  //////////////////////////////////////////////////
  // run state
  //////////////////////////////////////////////////

  // stop has priority over start in the same cycle
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      state   <= SEQ_IDLE;
      started <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (awg_start && !awg_stop) begin
            state   <= SEQ_ACTIVE;
            started <= 1'b1;
          end
        end
        SEQ_ACTIVE: if (awg_stop || (&done)) state <= SEQ_IDLE;
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // per-channel address and frame counters
  //////////////////////////////////////////////////

  // counters sit at zero while idle, so the first busy cycle issues address 0
  always_ff @(posedge dac_clk) begin
    if (dac_reset || !awg_busy) begin
      rd_addr   <= '0;
      frame_cnt <= '0;
      done      <= '0;
    end else begin
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        if (!done[ch]) begin
          if (rd_addr[ch] == last_addr[ch]) begin
            rd_addr[ch] <= '0;
            // last word of last frame, channel goes quiet next cycle
            if (frame_cnt[ch] == last_frame[ch]) begin
              done[ch] <= 1'b1;
            end else begin
              frame_cnt[ch] <= frame_cnt[ch] + 1'b1;
            end
          end else begin
            rd_addr[ch] <= rd_addr[ch] + 1'b1;
          end
        end
      end
    end
  end

  // zero select and trigger line up with the address of the same cycle
  always_comb begin
    for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
      zero_sel[ch] = !awg_busy || done[ch];
      raw_trig[ch] = !zero_sel[ch] && (rd_addr[ch] == '0) &&
                     ((trig_mode[ch] == TRIG_FRAME) ||
                      ((trig_mode[ch] == TRIG_BURST) && (frame_cnt[ch] == '0)));
    end
  end

  for (genvar ch = 0; ch < `AWG_CHANNELS; ch++) begin : g_addr_chk
    assert property (@(posedge dac_clk) disable iff (dac_reset)
      awg_busy |-> (rd_addr[ch] <= last_addr[ch]))
      else $error("read address past frame end on channel %0d", ch);
  end

  assert property (@(posedge dac_clk) disable iff (dac_reset)
    !awg_busy |-> (raw_trig == '0))
    else $error("trigger raised while idle");

endmodule

`default_nettype wire

//--- hdl/awg_top.sv
//////////////////////////////////////////////////
// awg top level
// config regs, sequencer, waveform memories and
// output stage chained on the dac clock
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module awg_top
  import awg_data_pkg::*;
  import awg_cfg_pkg::*;
(
  input  wire logic                       dac_clk,
  input  wire logic                       dac_reset,
  // waveform write port
  input  wire logic                       mem_wr,
  input  wire chan_idx_t                  mem_wr_chan,
  input  wire mem_addr_t                  mem_wr_addr,
  input  wire sample_word_t               mem_wr_data,
  // configuration write port
  input  wire logic                       cfg_wr,
  input  wire chan_idx_t                  cfg_chan,
  input  wire cfg_sel_e                   cfg_sel,
  input  wire cfg_word_u                  cfg_word,
  // playback control
  input  wire logic                       awg_start,
  input  wire logic                       awg_stop,
  output chan_words_t                     dac_data,
  output logic                            dac_valid,
  output logic [`AWG_CHANNELS-1:0]        dac_trigger,
  output logic                            awg_busy
);

  mem_addr_t  [`AWG_CHANNELS-1:0]                       last_addr;
  trig_mode_e [`AWG_CHANNELS-1:0]                       trig_mode;
  logic       [`AWG_CHANNELS-1:0][`AWG_BURST_WIDTH-1:0] last_frame;
  mem_addr_t  [`AWG_CHANNELS-1:0]                       rd_addr;
  logic       [`AWG_CHANNELS-1:0]                       zero_sel;
  logic       [`AWG_CHANNELS-1:0]                       raw_trig;
  logic                                                 started;
  chan_words_t                                          rd_data;

  awg_config_regs cfg_regs_i (
    .dac_clk, .dac_reset, .awg_busy, .cfg_wr, .cfg_chan, .cfg_sel, .cfg_word,
    .last_addr, .trig_mode, .last_frame
  );

  awg_sequencer seq_i (
    .dac_clk, .dac_reset, .awg_start, .awg_stop, .last_addr, .trig_mode, .last_frame,
    .awg_busy, .started, .rd_addr, .zero_sel, .raw_trig
  );

  awg_wave_mem mem_i (
    .dac_clk, .awg_busy, .mem_wr, .mem_wr_chan, .mem_wr_addr, .mem_wr_data,
    .rd_addr, .rd_data
  );

  awg_output_stage out_i (
    .dac_clk, .dac_reset, .zero_sel, .raw_trig, .started, .rd_data,
    .dac_data, .dac_trigger, .dac_valid
  );

endmodule

`default_nettype wire

//--- hdl/awg_wave_mem.sv
//////////////////////////////////////////////////
// awg waveform memories
// one sample memory per channel, single write
// port and a parallel read with two registers
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module awg_wave_mem
  import awg_data_pkg::*;
(
  input  wire logic                            dac_clk,
  input  wire logic                            awg_busy,
  input  wire logic                            mem_wr,
  input  wire chan_idx_t                       mem_wr_chan,
  input  wire mem_addr_t                       mem_wr_addr,
  input  wire sample_word_t                    mem_wr_data,
  input  wire mem_addr_t [`AWG_CHANNELS-1:0]   rd_addr,
  output chan_words_t                          rd_data
);

  for (genvar ch = 0; ch < `AWG_CHANNELS; ch++) begin : g_chan
    sample_word_t mem [`AWG_DEPTH];
    // ram output register, then the extra pipeline register
    sample_word_t rd_q0;
    sample_word_t rd_q1;

    // contents frozen during playback
    always_ff @(posedge dac_clk) begin
      if (mem_wr && !awg_busy && (mem_wr_chan == chan_idx_t'(ch))) begin
        mem[mem_wr_addr] <= mem_wr_data;
      end
    end

    // all channels read every cycle
    always_ff @(posedge dac_clk) begin
      rd_q0 <= mem[rd_addr[ch]];
      rd_q1 <= rd_q0;
    end

    assign rd_data[ch] = rd_q1;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the awg testbench with verilator
# a failing check ends in $fatal, which gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_awg \
  -Mdir obj_dir \
  -o sim_awg

./obj_dir/sim_awg

//--- tb/tb_awg.sv
//////////////////////////////////////////////////
// awg testbench
// drives waveform writes, config and playback runs
// against a cycle model, checked by assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "awg_params.svh"

module tb_awg
  import awg_data_pkg::*;
  import awg_cfg_pkg::*;
();

  // reset, memory fill, config, then five playback runs of at most 40 cycles
  localparam int PLAN_CYCLES = 16 + `AWG_CHANNELS * `AWG_DEPTH + 8 + 5 * 40 + 60;

  logic                     dac_clk;
  logic                     dac_reset;
  logic                     mem_wr;
  chan_idx_t                mem_wr_chan;
  mem_addr_t                mem_wr_addr;
  sample_word_t             mem_wr_data;
  logic                     cfg_wr;
  chan_idx_t                cfg_chan;
  cfg_sel_e                 cfg_sel;
  cfg_word_u                cfg_word;
  logic                     awg_start;
  logic                     awg_stop;
  chan_words_t              dac_data;
  logic                     dac_valid;
  logic [`AWG_CHANNELS-1:0] dac_trigger;
  logic                     awg_busy;
  integer                   seed;

  // model state: memories, config, run state and a 3 deep output pipe
  sample_word_t                                m_mem [`AWG_CHANNELS][`AWG_DEPTH];
  mem_addr_t                                   m_last_addr [`AWG_CHANNELS];
  trig_mode_e                                  m_mode [`AWG_CHANNELS];
  logic [`AWG_BURST_WIDTH-1:0]                 m_last_frame [`AWG_CHANNELS];
  logic                                        m_busy;
  logic                                        m_started;
  mem_addr_t                                   m_addr [`AWG_CHANNELS];
  logic [`AWG_BURST_WIDTH-1:0]                 m_frame [`AWG_CHANNELS];
  logic [`AWG_CHANNELS-1:0]                    m_done;
  chan_words_t                                 pipe_data [3];
  logic [`AWG_CHANNELS-1:0]                    pipe_trig [3];
  logic                                        pipe_valid [3];

  awg_top DUT (.*);

  initial begin
    dac_clk = 1'b0;
    forever #10 dac_clk = ~dac_clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  always @(posedge dac_clk) begin : model
    chan_words_t              issue_data;
    logic [`AWG_CHANNELS-1:0] issue_trig;
    logic                     gated;
    if (dac_reset) begin
      m_busy    <= 1'b0;
      m_started <= 1'b0;
      m_done    <= '0;
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        m_addr[ch]       <= '0;
        m_frame[ch]      <= '0;
        m_last_addr[ch]  <= '0;
        m_last_frame[ch] <= '0;
        m_mode[ch]       <= TRIG_NONE;
      end
      for (int i = 0; i < 3; i++) begin
        pipe_data[i]  <= '0;
        pipe_trig[i]  <= '0;
        pipe_valid[i] <= 1'b0;
      end
    end else begin
      // what the current addresses should produce three cycles later
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        gated          = !m_busy || m_done[ch];
        issue_data[ch] = gated ? '0 : m_mem[ch][m_addr[ch]];
        issue_trig[ch] = !gated && (m_addr[ch] == '0) &&
                         ((m_mode[ch] == TRIG_FRAME) ||
                          ((m_mode[ch] == TRIG_BURST) && (m_frame[ch] == '0)));
      end
      pipe_data[0]  <= issue_data;
      pipe_trig[0]  <= issue_trig;
      pipe_valid[0] <= m_started;
      for (int i = 1; i < 3; i++) begin
        pipe_data[i]  <= pipe_data[i-1];
        pipe_trig[i]  <= pipe_trig[i-1];
        pipe_valid[i] <= pipe_valid[i-1];
      end
      // writes land only while idle
      if (mem_wr && !m_busy) begin
        m_mem[mem_wr_chan][mem_wr_addr] <= mem_wr_data;
      end
      if (cfg_wr && !m_busy) begin
        if (cfg_sel == CFG_BURST) begin
          m_last_frame[cfg_chan] <= (cfg_word[15:0] == '0) ? '0 : cfg_word[15:0] - 1'b1;
        end else begin
          m_last_addr[cfg_chan] <= cfg_word[5:0];
          m_mode[cfg_chan]      <= trig_mode_e'(cfg_word[7:6]);
        end
      end
      // run state, stop beats start
      if (!m_busy) begin
        if (awg_start && !awg_stop) begin
          m_busy    <= 1'b1;
          m_started <= 1'b1;
        end
      end else if (awg_stop || (&m_done)) begin
        m_busy <= 1'b0;
      end
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        if (!m_busy) begin
          m_addr[ch]  <= '0;
          m_frame[ch] <= '0;
          m_done[ch]  <= 1'b0;
        end else if (!m_done[ch]) begin
          if (m_addr[ch] == m_last_addr[ch]) begin
            m_addr[ch] <= '0;
            if (m_frame[ch] == m_last_frame[ch]) m_done[ch] <= 1'b1;
            else m_frame[ch] <= m_frame[ch] + 1'b1;
          end else begin
            m_addr[ch] <= m_addr[ch] + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks, sampled mid-cycle
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "first mismatch reached");
  endtask

  assert property (@(negedge dac_clk) dac_data == pipe_data[2])
    else report_mismatch("burst playback data", pipe_data[2], dac_data);
  assert property (@(negedge dac_clk) dac_trigger == pipe_trig[2])
    else report_mismatch("trigger modes", 128'(pipe_trig[2]), 128'(dac_trigger));
  assert property (@(negedge dac_clk) dac_valid == pipe_valid[2])
    else report_mismatch("sticky valid", 128'(pipe_valid[2]), 128'(dac_valid));
  assert property (@(negedge dac_clk) awg_busy == m_busy)
    else report_mismatch("busy flag", 128'(m_busy), 128'(awg_busy));
  // quiet outputs until the first start has worked through
  assert property (@(negedge dac_clk) !pipe_valid[2] |-> (dac_data == '0))
    else report_mismatch("reset state data", '0, dac_data);
  assert property (@(negedge dac_clk) !pipe_valid[2] |-> (dac_trigger == '0))
    else report_mismatch("reset state trigger", '0, 128'(dac_trigger));

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic write_mem(input int ch, input int addr, input sample_word_t data);
    mem_wr      = 1'b1;
    mem_wr_chan = chan_idx_t'(ch);
    mem_wr_addr = mem_addr_t'(addr);
    mem_wr_data = data;
    @(posedge dac_clk);
    #2;
    mem_wr = 1'b0;
  endtask

  // frame fields first, then the frame count
  task automatic set_channel(input int ch, input int last, input trig_mode_e mode,
                             input int frames);
    cfg_wr   = 1'b1;
    cfg_chan = chan_idx_t'(ch);
    cfg_sel  = CFG_FRAME;
    cfg_word = cfg_word_u'({24'd0, mode, 6'(last)});
    @(posedge dac_clk);
    #2;
    cfg_sel  = CFG_BURST;
    cfg_word = cfg_word_u'({16'd0, 16'(frames)});
    @(posedge dac_clk);
    #2;
    cfg_wr = 1'b0;
  endtask

  task automatic pulse_control(input logic start, input logic stop);
    awg_start = start;
    awg_stop  = stop;
    @(posedge dac_clk);
    #2;
    awg_start = 1'b0;
    awg_stop  = 1'b0;
  endtask

  task automatic wait_idle(input int limit);
    int cycles;
    cycles = 0;
    while (awg_busy) begin
      @(posedge dac_clk);
      #2;
      cycles++;
      if (cycles > limit) begin
        $display("playback did not return to idle within %0d cycles", limit);
        $display("Simulation FAILED");
        $fatal(1, "idle wait timed out");
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge dac_clk);
    #2;
  endtask

  initial begin
    seed        = 84;
    dac_reset   = 1'b1;
    mem_wr      = 1'b0;
    mem_wr_chan = '0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    cfg_wr      = 1'b0;
    cfg_chan    = '0;
    cfg_sel     = CFG_FRAME;
    cfg_word    = '0;
    awg_start   = 1'b0;
    awg_stop    = 1'b0;
    repeat (16) @(posedge dac_clk);
    #2;
    dac_reset = 1'b0;
    // random contents over every address of every channel
    for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
      for (int a = 0; a < `AWG_DEPTH; a++) begin
        write_mem(ch, a, $random(seed));
      end
    end
    // channel 3 asks for zero frames and still plays one
    set_channel(0, 3, TRIG_NONE, 3);
    set_channel(1, 7, TRIG_BURST, 2);
    set_channel(2, 5, TRIG_FRAME, 4);
    set_channel(3, 1, TRIG_FRAME, 0);
    idle_cycles(4);
    // burst playback with all three trigger modes
    pulse_control(1'b1, 1'b0);
    wait_idle(60);
    idle_cycles(8);
    // start and stop together stays idle
    pulse_control(1'b1, 1'b1);
    idle_cycles(4);
    // stop part way through
    pulse_control(1'b1, 1'b0);
    idle_cycles(10);
    pulse_control(1'b0, 1'b1);
    wait_idle(4);
    idle_cycles(8);
    // writes while busy are dropped
    pulse_control(1'b1, 1'b0);
    write_mem(0, 0, ~$random(seed));
    write_mem(2, 3, $random(seed));
    set_channel(1, 2, TRIG_FRAME, 9);
    wait_idle(60);
    idle_cycles(4);
    // replay must match the untouched contents
    pulse_control(1'b1, 1'b0);
    wait_idle(60);
    idle_cycles(8);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #((PLAN_CYCLES + 200) * 20);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire
